//--- Makefile
# pdp11_mini simulation with Verilator

TOP = tb_pdp11_mini

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f all.f

run: build
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f all.f

clean:
	rm -rf obj_dir

//--- all.f
logic/pdp11_pkg.sv
logic/alu.sv
logic/isn_decode.sv
logic/register_file.sv
logic/word_memory.sv
logic/control_fsm.sv
logic/pdp11_mini.sv
verification/pdp11_mini_sva.sv
verification/tb_pdp11_mini.sv

//--- logic/alu.sv
////////////////////////////////////////
// alu: result, condition codes and
// branch decision, all combinational
////////////////////////////////////////
`timescale 1ns/1ps

module alu (
   input  pdp11_pkg::op_t   op,
   input  pdp11_pkg::word_t src_data,
   input  pdp11_pkg::word_t dst_data,
   input  pdp11_pkg::cc_t   cc_in,
   output pdp11_pkg::word_t result,
   output pdp11_pkg::cc_t   new_cc,
   output logic             branch_taken
);

   logic [16:0] wide;   // bit 16 is carry or borrow
   logic        v, c;

   always_comb
   begin
      wide = {1'b0, src_data};
      v    = 1'b0;
      c    = 1'b0;
      case (op)
         pdp11_pkg::op_add:
         begin
            wide = {1'b0, dst_data} + {1'b0, src_data};
            v    = (dst_data[15] == src_data[15]) && (wide[15] != src_data[15]);
            c    = wide[16];
         end
         pdp11_pkg::op_sub:
         begin
            wide = {1'b0, dst_data} - {1'b0, src_data};
            v    = (dst_data[15] != src_data[15]) && (wide[15] == src_data[15]);
            c    = wide[16];
         end
         pdp11_pkg::op_cmp:
         begin
            wide = {1'b0, src_data} - {1'b0, dst_data};   // note reversed order
            v    = (src_data[15] != dst_data[15]) && (wide[15] == dst_data[15]);
            c    = wide[16];
         end
         pdp11_pkg::op_bit: wide = {1'b0, src_data & dst_data};
         pdp11_pkg::op_clr: wide = 17'd0;
         pdp11_pkg::op_inc:
         begin
            wide = {1'b0, dst_data + 16'd1};
            v    = (dst_data == 16'h7fff);
            c    = cc_in[0];   // carry untouched
         end
         pdp11_pkg::op_dec:
         begin
            wide = {1'b0, dst_data - 16'd1};
            v    = (dst_data == 16'h8000);
            c    = cc_in[0];
         end
         pdp11_pkg::op_tst: wide = {1'b0, dst_data};
         default: wide = {1'b0, src_data};   // mov, and don't care for branches
      endcase
   end

   assign result = wide[15:0];
   assign new_cc = {wide[15], wide[15:0] == 16'd0, v, c};

   always_comb
   begin
      case (op)
         pdp11_pkg::op_br:  branch_taken = 1'b1;
         pdp11_pkg::op_bne: branch_taken = !cc_in[2];
         pdp11_pkg::op_beq: branch_taken = cc_in[2];
         default:           branch_taken = 1'b0;
      endcase
   end

endmodule

//--- logic/control_fsm.sv
////////////////////////////////////////
// instruction sequencer
// drives bus, register writes and cc
////////////////////////////////////////
`timescale 1ns/1ps

module control_fsm (
   input  logic                clk,
   input  logic                reset_n,
   input  pdp11_pkg::word_t    bus_rdata,
   input  pdp11_pkg::op_t      op,
   input  pdp11_pkg::mode_t    src_mode,
   input  pdp11_pkg::reg_sel_t src_reg,
   input  pdp11_pkg::mode_t    dst_mode,
   input  pdp11_pkg::reg_sel_t dst_reg,
   input  pdp11_pkg::word_t    branch_offset,
   input  pdp11_pkg::word_t    src_value,
   input  pdp11_pkg::word_t    dst_value,
   input  pdp11_pkg::word_t    pc,
   input  pdp11_pkg::word_t    result,
   input  pdp11_pkg::cc_t      new_cc,
   input  logic                branch_taken,
   output pdp11_pkg::word_t    bus_addr,
   output logic                bus_wr,
   output pdp11_pkg::word_t    bus_wdata,
   output pdp11_pkg::word_t    isn,
   output pdp11_pkg::reg_sel_t src_sel,
   output pdp11_pkg::reg_sel_t dst_sel,
   output logic                reg_wr,
   output pdp11_pkg::reg_sel_t reg_wr_sel,
   output pdp11_pkg::word_t    reg_wr_data,
   output pdp11_pkg::word_t    src_data,
   output pdp11_pkg::word_t    dst_data,
   output pdp11_pkg::cc_t      cc,
   output logic                halted,
   output logic                illegal
);

   pdp11_pkg::state_t state, state_next;
   pdp11_pkg::word_t  src_ea, dst_ea;
   logic              has_src, is_branch, reads_dst, stores_result, stop;

   assign has_src = op inside {pdp11_pkg::op_mov, pdp11_pkg::op_add, pdp11_pkg::op_sub,
                               pdp11_pkg::op_cmp, pdp11_pkg::op_bit};
   assign is_branch = op inside {pdp11_pkg::op_br, pdp11_pkg::op_bne, pdp11_pkg::op_beq};
   assign stop = op inside {pdp11_pkg::op_halt, pdp11_pkg::op_illegal};
   assign reads_dst = !(op inside {pdp11_pkg::op_mov, pdp11_pkg::op_clr});   // write only
   assign stores_result = !(op inside {pdp11_pkg::op_cmp, pdp11_pkg::op_bit,
                                       pdp11_pkg::op_tst});

   assign src_sel = src_reg;
   assign dst_sel = dst_reg;

   always_comb
   begin
      state_next = state;
      case (state)
         pdp11_pkg::st_fetch: state_next = pdp11_pkg::st_decode;
         pdp11_pkg::st_decode:
         begin
            if (stop)
               state_next = pdp11_pkg::st_halt;
            else if (is_branch)
               state_next = pdp11_pkg::st_execute;
            else if (has_src && src_mode != pdp11_pkg::mode_reg)
               state_next = pdp11_pkg::st_src_ea;
            else if (dst_mode != pdp11_pkg::mode_reg)
               state_next = pdp11_pkg::st_dst_ea;
            else
               state_next = pdp11_pkg::st_execute;
         end
         pdp11_pkg::st_src_ea: state_next = pdp11_pkg::st_src_read;
         pdp11_pkg::st_src_read:
            state_next = (dst_mode != pdp11_pkg::mode_reg) ? pdp11_pkg::st_dst_ea
                                                           : pdp11_pkg::st_execute;
         pdp11_pkg::st_dst_ea:
            state_next = reads_dst ? pdp11_pkg::st_dst_read : pdp11_pkg::st_execute;
         pdp11_pkg::st_dst_read: state_next = pdp11_pkg::st_execute;
         pdp11_pkg::st_execute:
            state_next = is_branch ? pdp11_pkg::st_fetch : pdp11_pkg::st_writeback;
         pdp11_pkg::st_writeback: state_next = pdp11_pkg::st_fetch;
         default: state_next = pdp11_pkg::st_halt;   // halt is sticky
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state   <= pdp11_pkg::st_fetch;
         cc      <= 4'd0;
         halted  <= 1'b0;
         illegal <= 1'b0;
      end
      else
      begin
         state <= state_next;
         if (state == pdp11_pkg::st_execute && !is_branch)
            cc <= new_cc;
         if (state == pdp11_pkg::st_decode && stop)
         begin
            halted  <= 1'b1;
            illegal <= (op == pdp11_pkg::op_illegal);
         end
      end
   end

   // instruction, addresses and operands
   always_ff @(posedge clk)
   begin
      case (state)
         pdp11_pkg::st_fetch: isn <= bus_rdata;
         pdp11_pkg::st_decode:
         begin
            src_data <= src_value;   // mode 0 operands taken here
            dst_data <= dst_value;
         end
         pdp11_pkg::st_src_ea:   src_ea <= src_value;
         pdp11_pkg::st_src_read: src_data <= bus_rdata;
         pdp11_pkg::st_dst_ea:   dst_ea <= dst_value;
         pdp11_pkg::st_dst_read: dst_data <= bus_rdata;
         default: ;
      endcase
   end

   always_comb
   begin
      reg_wr      = 1'b0;
      reg_wr_sel  = dst_reg;
      reg_wr_data = result;
      case (state)
         pdp11_pkg::st_fetch:
         begin
            reg_wr      = 1'b1;
            reg_wr_sel  = pdp11_pkg::pc_reg;
            reg_wr_data = pc + pdp11_pkg::word_step;
         end
         pdp11_pkg::st_src_ea:
         begin
            reg_wr      = (src_mode == pdp11_pkg::mode_autoinc);   // (rn)+, #imm on r7
            reg_wr_sel  = src_reg;
            reg_wr_data = src_value + pdp11_pkg::word_step;
         end
         pdp11_pkg::st_dst_ea:
         begin
            reg_wr      = (dst_mode == pdp11_pkg::mode_autoinc);
            reg_wr_data = dst_value + pdp11_pkg::word_step;
         end
         pdp11_pkg::st_execute:
         begin
            reg_wr      = is_branch && branch_taken;
            reg_wr_sel  = pdp11_pkg::pc_reg;
            reg_wr_data = pc + branch_offset;
         end
         pdp11_pkg::st_writeback:
            reg_wr = stores_result && (dst_mode == pdp11_pkg::mode_reg);
         default: ;
      endcase
   end

   always_comb
   begin
      case (state)
         pdp11_pkg::st_fetch:    bus_addr = pc;
         pdp11_pkg::st_src_read: bus_addr = src_ea;
         default:                bus_addr = dst_ea;
      endcase
   end

   assign bus_wr = (state == pdp11_pkg::st_writeback) && stores_result &&
                   (dst_mode != pdp11_pkg::mode_reg);
   assign bus_wdata = result;

endmodule

//--- logic/isn_decode.sv
////////////////////////////////////////
// instruction decoder
// opcode class, operand fields, offset
////////////////////////////////////////
`timescale 1ns/1ps

module isn_decode (
   input  pdp11_pkg::word_t    isn,
   output pdp11_pkg::op_t      op,
   output pdp11_pkg::mode_t    src_mode,
   output pdp11_pkg::reg_sel_t src_reg,
   output pdp11_pkg::mode_t    dst_mode,
   output pdp11_pkg::reg_sel_t dst_reg,
   output pdp11_pkg::word_t    branch_offset
);

   pdp11_pkg::op_t op_raw;
   logic           dbl_op, sgl_op, bad_mode;

   assign src_mode = isn[11:9];
   assign src_reg  = isn[8:6];
   assign dst_mode = isn[5:3];
   assign dst_reg  = isn[2:0];

   // 8-bit word offset, sign extended and scaled to bytes
   assign branch_offset = {{7{isn[7]}}, isn[7:0], 1'b0};

   always_comb
   begin
      op_raw = pdp11_pkg::op_illegal;
      if (isn == pdp11_pkg::opc_halt)
         op_raw = pdp11_pkg::op_halt;
      else if (isn[15:8] == pdp11_pkg::opc_br)
         op_raw = pdp11_pkg::op_br;
      else if (isn[15:8] == pdp11_pkg::opc_bne)
         op_raw = pdp11_pkg::op_bne;
      else if (isn[15:8] == pdp11_pkg::opc_beq)
         op_raw = pdp11_pkg::op_beq;
      else if (isn[15:6] == pdp11_pkg::opc_clr)
         op_raw = pdp11_pkg::op_clr;
      else if (isn[15:6] == pdp11_pkg::opc_inc)
         op_raw = pdp11_pkg::op_inc;
      else if (isn[15:6] == pdp11_pkg::opc_dec)
         op_raw = pdp11_pkg::op_dec;
      else if (isn[15:6] == pdp11_pkg::opc_tst)
         op_raw = pdp11_pkg::op_tst;
      else
      begin
         case (isn[15:12])
            pdp11_pkg::opc_mov: op_raw = pdp11_pkg::op_mov;
            pdp11_pkg::opc_add: op_raw = pdp11_pkg::op_add;
            pdp11_pkg::opc_sub: op_raw = pdp11_pkg::op_sub;
            pdp11_pkg::opc_cmp: op_raw = pdp11_pkg::op_cmp;
            pdp11_pkg::opc_bit: op_raw = pdp11_pkg::op_bit;
            default:            op_raw = pdp11_pkg::op_illegal;
         endcase
      end
   end

   assign dbl_op = op_raw inside {pdp11_pkg::op_mov, pdp11_pkg::op_add, pdp11_pkg::op_sub,
                                  pdp11_pkg::op_cmp, pdp11_pkg::op_bit};
   assign sgl_op = op_raw inside {pdp11_pkg::op_clr, pdp11_pkg::op_inc, pdp11_pkg::op_dec,
                                  pdp11_pkg::op_tst};

   // modes 3..7 not built, src field only meaningful on double operand
   assign bad_mode = (dbl_op && src_mode > pdp11_pkg::mode_autoinc) ||
                     ((dbl_op || sgl_op) && dst_mode > pdp11_pkg::mode_autoinc);

   assign op = bad_mode ? pdp11_pkg::op_illegal : op_raw;

endmodule

//--- logic/pdp11_mini.sv
////////////////////////////////////////
// pdp11_mini top level
// sequencer, decoder, alu, registers, ram
////////////////////////////////////////
`timescale 1ns/1ps

module pdp11_mini #(
   parameter pdp11_pkg::word_t reset_pc  = 16'o500,
   parameter int               mem_words = 4096
) (
   input  logic                clk,
   input  logic                reset_n,
   input  logic                load_en,
   input  pdp11_pkg::word_t    load_addr,   // byte address
   input  pdp11_pkg::word_t    load_data,
   input  pdp11_pkg::word_t    peek_addr,
   output pdp11_pkg::word_t    peek_data,
   output logic                halted,
   output logic                illegal,
   output pdp11_pkg::cc_t      cc
);

   pdp11_pkg::word_t    bus_addr, bus_wdata, bus_rdata;
   logic                bus_wr;
   pdp11_pkg::word_t    isn, branch_offset;
   pdp11_pkg::op_t      op;
   pdp11_pkg::mode_t    src_mode, dst_mode;
   pdp11_pkg::reg_sel_t src_reg, dst_reg, src_sel, dst_sel, reg_wr_sel;
   pdp11_pkg::word_t    src_value, dst_value, pc, reg_wr_data;
   logic                reg_wr;
   pdp11_pkg::word_t    src_data, dst_data, result;
   pdp11_pkg::cc_t      new_cc;
   logic                branch_taken;

   control_fsm control_fsm_inst (.*);

   isn_decode isn_decode_inst (.*);

   register_file #(.reset_pc(reset_pc)) register_file_inst (.*);

   alu alu_inst (.*, .cc_in(cc));   // flags fed back for inc/dec and branches

   word_memory #(.mem_words(mem_words)) word_memory_inst (.*);

endmodule

//--- logic/pdp11_pkg.sv
////////////////////////////////////////
// pdp11_mini shared definitions
// word types, sequencer states, opcodes
////////////////////////////////////////
package pdp11_pkg;

   typedef logic [15:0] word_t;      // data word or byte address
   typedef logic [2:0]  reg_sel_t;   // r0..r7
   typedef logic [2:0]  mode_t;
   typedef logic [3:0]  cc_t;        // n z v c

   typedef enum logic [3:0] {
      st_fetch,
      st_decode,
      st_src_ea,
      st_src_read,
      st_dst_ea,
      st_dst_read,
      st_execute,
      st_writeback,
      st_halt
   } state_t;

   typedef enum logic [3:0] {
      op_mov, op_add, op_sub, op_cmp, op_bit,
      op_clr, op_inc, op_dec, op_tst,
      op_br, op_bne, op_beq,
      op_halt, op_illegal
   } op_t;

   localparam word_t    word_step = 16'd2;   // one word in bytes
   localparam reg_sel_t pc_reg    = 3'd7;

   // addressing modes still supported
   localparam mode_t mode_reg     = 3'd0;
   localparam mode_t mode_autoinc = 3'd2;    // highest legal mode

   // double operand, isn[15:12]
   localparam logic [3:0] opc_mov = 4'o01;
   localparam logic [3:0] opc_cmp = 4'o02;
   localparam logic [3:0] opc_bit = 4'o03;
   localparam logic [3:0] opc_add = 4'o06;
   localparam logic [3:0] opc_sub = 4'o16;

   // single operand, isn[15:6]
   localparam logic [9:0] opc_clr = 10'o0050;
   localparam logic [9:0] opc_inc = 10'o0052;
   localparam logic [9:0] opc_dec = 10'o0053;
   localparam logic [9:0] opc_tst = 10'o0057;

   // branches, isn[15:8] (000400, 001000, 001400)
   localparam logic [7:0] opc_br  = 8'h01;
   localparam logic [7:0] opc_bne = 8'h02;
   localparam logic [7:0] opc_beq = 8'h03;

   localparam word_t opc_halt = 16'o000000;

endpackage

//--- logic/register_file.sv
////////////////////////////////////////
// general registers r0..r7
// two read ports, one write, r7 is pc
////////////////////////////////////////
`timescale 1ns/1ps

module register_file #(
   parameter pdp11_pkg::word_t reset_pc = 16'o500
) (
   input  logic                clk,
   input  logic                reset_n,
   input  pdp11_pkg::reg_sel_t src_sel,
   input  pdp11_pkg::reg_sel_t dst_sel,
   input  logic                reg_wr,
   input  pdp11_pkg::reg_sel_t reg_wr_sel,
   input  pdp11_pkg::word_t    reg_wr_data,
   output pdp11_pkg::word_t    src_value,
   output pdp11_pkg::word_t    dst_value,
   output pdp11_pkg::word_t    pc
);

   pdp11_pkg::word_t regs [8];

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         for (int i = 0; i < 8; i++)
         begin
            regs[i] <= (i == int'(pdp11_pkg::pc_reg)) ? reset_pc : 16'd0;
         end
      end
      else if (reg_wr)
         regs[reg_wr_sel] <= reg_wr_data;
   end

   assign src_value = regs[src_sel];
   assign dst_value = regs[dst_sel];
   assign pc        = regs[pdp11_pkg::pc_reg];

endmodule

//--- logic/word_memory.sv
////////////////////////////////////////
// single cycle word ram
// cpu, load and peek ports
////////////////////////////////////////
`timescale 1ns/1ps

module word_memory #(
   parameter int mem_words = 4096
) (
   input  logic             clk,
   input  pdp11_pkg::word_t bus_addr,
   input  logic             bus_wr,
   input  pdp11_pkg::word_t bus_wdata,
   input  logic             load_en,
   input  pdp11_pkg::word_t load_addr,
   input  pdp11_pkg::word_t load_data,
   input  pdp11_pkg::word_t peek_addr,
   output pdp11_pkg::word_t bus_rdata,
   output pdp11_pkg::word_t peek_data
);

   localparam int aw = $clog2(mem_words);   // word index bits

   pdp11_pkg::word_t mem [mem_words];

   always_ff @(posedge clk)
   begin
      if (load_en)   // loader wins over cpu
         mem[load_addr[aw:1]] <= load_data;
      else if (bus_wr)
         mem[bus_addr[aw:1]] <= bus_wdata;
   end

   // byte addresses, bit 0 ignored
   assign bus_rdata = mem[bus_addr[aw:1]];
   assign peek_data = mem[peek_addr[aw:1]];

endmodule

//--- verification/pdp11_mini_sva.sv
////////////////////////////////////////
// sequencer assertions, bound into
// control_fsm
////////////////////////////////////////
`timescale 1ns/1ps

module pdp11_mini_sva (
   input logic              clk,
   input logic              reset_n,
   input pdp11_pkg::state_t state,
   input logic              bus_wr,
   input logic              halted,
   input logic              illegal
);

   // memory only written at the end of an instruction
   wr_in_writeback: assert property (@(posedge clk) disable iff (!reset_n)
                                     bus_wr |-> state == pdp11_pkg::st_writeback)
      else $error("bus write outside writeback");

   halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
                                 halted |=> halted)   // only reset restarts
      else $error("halted dropped without reset");

   illegal_halts: assert property (@(posedge clk) disable iff (!reset_n)
                                   illegal |-> halted)
      else $error("illegal flag set while running");

endmodule

//--- verification/tb_pdp11_mini.sv
////////////////////////////////////////
// directed testbench for pdp11_mini
// loads small programs, runs to halt,
// checks memory words and flags
////////////////////////////////////////
`timescale 1ns/1ps

module tb_pdp11_mini;

   localparam pdp11_pkg::word_t reset_pc   = 16'o500;
   localparam pdp11_pkg::word_t data_base  = 16'o2000;
   localparam int               data_words = 32;
   localparam int               halt_limit = 2000;   // cycles per program

   localparam logic [3:0] dop_mov = 4'o01;
   localparam logic [3:0] dop_cmp = 4'o02;
   localparam logic [3:0] dop_bit = 4'o03;
   localparam logic [3:0] dop_add = 4'o06;
   localparam logic [3:0] dop_sub = 4'o16;
   localparam logic [9:0] sop_clr = 10'o0050;
   localparam logic [9:0] sop_inc = 10'o0052;
   localparam logic [9:0] sop_dec = 10'o0053;
   localparam logic [9:0] sop_tst = 10'o0057;
   localparam logic [7:0] br_bne  = 8'h02;   // 001000
   localparam logic [7:0] br_beq  = 8'h03;   // 001400
   localparam pdp11_pkg::word_t halt_isn = 16'o000000;

   logic             clk;
   logic             reset_n;
   logic             load_en;
   pdp11_pkg::word_t load_addr;
   pdp11_pkg::word_t load_data;
   pdp11_pkg::word_t peek_addr;
   pdp11_pkg::word_t peek_data;
   logic             halted;
   logic             illegal;
   pdp11_pkg::cc_t   cc;

   pdp11_pkg::word_t prog [$];   // image placed at reset_pc

   pdp11_mini #(.reset_pc(reset_pc), .mem_words(4096)) pdp11_mini_inst (.*);

   bind control_fsm pdp11_mini_sva control_fsm_sva_inst (
      .clk(clk),
      .reset_n(reset_n),
      .state(state),
      .bus_wr(bus_wr),
      .halted(halted),
      .illegal(illegal)
   );

   initial clk = 1'b0;
   always #5 clk = ~clk;

   function automatic pdp11_pkg::word_t encode_double(input logic [3:0] opc,
                                                      input logic [2:0] sm, input logic [2:0] sr,
                                                      input logic [2:0] dm, input logic [2:0] dr);
      return {opc, sm, sr, dm, dr};
   endfunction

   function automatic pdp11_pkg::word_t encode_single(input logic [9:0] opc,
                                                      input logic [2:0] dm, input logic [2:0] dr);
      return {opc, dm, dr};
   endfunction

   function automatic pdp11_pkg::word_t encode_branch(input logic [7:0] opc,
                                                      input logic [7:0] offset);
      return {opc, offset};   // offset in words
   endfunction

   // known contents of the data area before each run
   function automatic pdp11_pkg::word_t fill_word(input pdp11_pkg::word_t addr);
      return {addr[7:0], addr[15:8]} ^ 16'hc35a;
   endfunction

   task automatic emit_mov_imm(input pdp11_pkg::word_t value, input logic [2:0] dm,
                               input logic [2:0] dr);
      prog.push_back(encode_double(dop_mov, 3'd2, 3'd7, dm, dr));   // mov #value, dst
      prog.push_back(value);
   endtask

   task automatic check_value(input string what, input pdp11_pkg::word_t actual,
                              input pdp11_pkg::word_t expected);
      if (actual !== expected)
      begin
         $display("** Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
         $display("CHECKS FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic check_word(input pdp11_pkg::word_t addr, input pdp11_pkg::word_t expected);
      @(posedge clk);
      #1;
      peek_addr = addr;
      #1;
      check_value($sformatf("mem[%o]", addr), peek_data, expected);
   endtask

   task automatic check_cc(input pdp11_pkg::cc_t expected);
      check_value("cc", 16'(cc), 16'(expected));
   endtask

   // load under reset, release, wait for halted
   task automatic run_program();
      int n;
      int cycles;
      @(posedge clk);
      #1;
      reset_n = 1'b0;
      for (n = 0; n < prog.size() + data_words; n++)
      begin
         load_en = 1'b1;
         if (n < prog.size())
         begin
            load_addr = reset_pc + 16'(2 * n);
            load_data = prog[n];
         end
         else
         begin
            load_addr = data_base + 16'(2 * (n - prog.size()));
            load_data = fill_word(load_addr);
         end
         @(posedge clk);
         #1;
      end
      load_en = 1'b0;
      prog.delete();
      repeat (3) @(posedge clk);
      #1;
      check_value("halted in reset", 16'(halted), 16'd0);
      check_value("illegal in reset", 16'(illegal), 16'd0);
      reset_n = 1'b1;
      cycles = 0;
      while (halted !== 1'b1)
      begin
         if (cycles == halt_limit)
         begin
            $display("processor never halted within %0d cycles", halt_limit);
            $display("CHECKS FAILED");
            $fatal(1, "halt timeout");
         end
         @(posedge clk);
         #1;
         cycles++;
      end
   endtask

   task automatic test_mov_store();
      pdp11_pkg::word_t value;
      pdp11_pkg::word_t addr;
      value = 16'($urandom);
      addr  = data_base + 16'(2 * ($urandom % 16));
      emit_mov_imm(value, 3'd0, 3'd0);
      emit_mov_imm(addr, 3'd0, 3'd1);
      prog.push_back(encode_double(dop_mov, 3'd0, 3'd0, 3'd1, 3'd1));   // mov r0, (r1)
      prog.push_back(halt_isn);
      run_program();
      check_word(addr, value);
      check_cc({value[15], value == 16'd0, 2'b00});
   endtask

   // op on a word at (r1) that was first set to init
   task automatic word_op_case(input pdp11_pkg::word_t isn, input logic with_imm,
                               input pdp11_pkg::word_t imm, input pdp11_pkg::word_t init,
                               input pdp11_pkg::word_t exp_word, input pdp11_pkg::cc_t exp_cc);
      pdp11_pkg::word_t addr;
      addr = data_base + 16'(2 * ($urandom % 16));
      emit_mov_imm(addr, 3'd0, 3'd1);
      emit_mov_imm(init, 3'd1, 3'd1);
      prog.push_back(isn);
      if (with_imm)
         prog.push_back(imm);
      prog.push_back(halt_isn);
      run_program();
      check_word(addr, exp_word);
      check_cc(exp_cc);
   endtask

   task automatic add_sub_case(input logic is_sub, input pdp11_pkg::word_t a,
                               input pdp11_pkg::word_t b);
      pdp11_pkg::word_t r;
      pdp11_pkg::word_t isn;
      logic             v;
      logic             c;
      if (is_sub)
      begin
         r   = a - b;
         c   = (a < b);   // borrow
         v   = (a[15] != b[15]) && (r[15] != a[15]);
         isn = encode_double(dop_sub, 3'd2, 3'd7, 3'd1, 3'd1);
      end
      else
      begin
         r   = a + b;
         c   = (r < a);   // wrapped past ffff
         v   = (a[15] == b[15]) && (r[15] != a[15]);
         isn = encode_double(dop_add, 3'd2, 3'd7, 3'd1, 3'd1);
      end
      word_op_case(isn, 1'b1, b, a, r, {r[15], r == 16'd0, v, c});
   endtask

   task automatic test_add_sub();
      int i;
      for (i = 0; i < 3; i++)
      begin
         add_sub_case(1'b0, 16'($urandom), 16'($urandom));
         add_sub_case(1'b1, 16'($urandom), 16'($urandom));
      end
      add_sub_case(1'b0, 16'hffff, 16'h0001);
      add_sub_case(1'b1, 16'h0001, 16'h0002);
      add_sub_case(1'b1, 16'h8000, 16'h0001);
   endtask

   // fall through stores via r1, taken branch via r2
   task automatic branch_case(input logic use_bne, input pdp11_pkg::word_t x,
                              input pdp11_pkg::word_t y);
      pdp11_pkg::word_t addr_fall;
      pdp11_pkg::word_t addr_jump;
      logic             taken;
      addr_fall = data_base;
      addr_jump = data_base + 16'd2;
      taken     = use_bne ? (x != y) : (x == y);
      emit_mov_imm(addr_fall, 3'd0, 3'd1);
      emit_mov_imm(addr_jump, 3'd0, 3'd2);
      emit_mov_imm(x, 3'd0, 3'd0);
      prog.push_back(encode_double(dop_cmp, 3'd2, 3'd7, 3'd0, 3'd0));   // cmp #y, r0
      prog.push_back(y);
      prog.push_back(encode_branch(use_bne ? br_bne : br_beq, 8'd3));
      emit_mov_imm(16'o111111, 3'd1, 3'd1);
      prog.push_back(halt_isn);
      emit_mov_imm(16'o122222, 3'd1, 3'd2);
      prog.push_back(halt_isn);
      run_program();
      check_word(addr_fall, taken ? fill_word(addr_fall) : 16'o111111);
      check_word(addr_jump, taken ? 16'o122222 : fill_word(addr_jump));
   endtask

   task automatic test_branches();
      pdp11_pkg::word_t x;
      pdp11_pkg::word_t y;
      x = 16'($urandom);
      y = x ^ (16'($urandom) | 16'd1);   // never equal to x
      branch_case(1'b0, x, x);
      branch_case(1'b0, x, y);
      branch_case(1'b1, x, x);
      branch_case(1'b1, x, y);
   endtask

   task automatic test_loop();
      pdp11_pkg::word_t value;
      int               count;
      int               i;
      value = 16'($urandom);
      count = 1 + int'($urandom % 8);
      emit_mov_imm(data_base, 3'd0, 3'd1);
      emit_mov_imm(16'(count), 3'd0, 3'd2);
      emit_mov_imm(value, 3'd2, 3'd1);   // mov #value, (r1)+
      prog.push_back(encode_single(sop_dec, 3'd0, 3'd2));
      prog.push_back(encode_branch(br_bne, 8'hfc));   // back to the store
      prog.push_back(halt_isn);
      run_program();
      for (i = 0; i < count; i++)
         check_word(data_base + 16'(2 * i), value);
      check_word(data_base + 16'(2 * count), fill_word(data_base + 16'(2 * count)));
      check_cc(4'b0100);   // z from last dec, c still clear from mov
   endtask

   task automatic test_single_ops();
      pdp11_pkg::word_t v;
      pdp11_pkg::word_t r;
      pdp11_pkg::word_t k;
      v = 16'($urandom);
      r = v + 16'd1;
      k = 16'($urandom);
      word_op_case(encode_single(sop_clr, 3'd1, 3'd1), 1'b0, 16'd0, v, 16'd0, 4'b0100);
      word_op_case(encode_single(sop_inc, 3'd1, 3'd1), 1'b0, 16'd0, v, r,
                   {r[15], r == 16'd0, v == 16'h7fff, 1'b0});
      word_op_case(encode_single(sop_inc, 3'd1, 3'd1), 1'b0, 16'd0, 16'h7fff, 16'h8000,
                   4'b1010);
      word_op_case(encode_single(sop_tst, 3'd1, 3'd1), 1'b0, 16'd0, v, v,
                   {v[15], v == 16'd0, 2'b00});
      // bit #k, (r1) leaves memory alone
      word_op_case(encode_double(dop_bit, 3'd2, 3'd7, 3'd1, 3'd1), 1'b1, ~v, v, v, 4'b0100);
      word_op_case(encode_double(dop_bit, 3'd2, 3'd7, 3'd1, 3'd1), 1'b1, 16'h8001, 16'h8000,
                   16'h8000, 4'b1000);
      word_op_case(encode_double(dop_bit, 3'd2, 3'd7, 3'd1, 3'd1), 1'b1, k, v, v,
                   {k[15] & v[15], (k & v) == 16'd0, 2'b00});
   endtask

   task automatic test_illegal();
      emit_mov_imm(data_base, 3'd0, 3'd1);
      emit_mov_imm(16'($urandom), 3'd0, 3'd0);
      prog.push_back(encode_double(dop_mov, 3'd0, 3'd0, 3'd3, 3'd1));   // mov r0, @(r1)+
      prog.push_back(encode_double(dop_mov, 3'd0, 3'd0, 3'd1, 3'd1));
      prog.push_back(halt_isn);
      run_program();
      check_value("illegal", 16'(illegal), 16'd1);
      check_word(data_base, fill_word(data_base));
      prog.push_back(halt_isn);   // plain halt after a fresh reset
      run_program();
      check_value("illegal after halt", 16'(illegal), 16'd0);
   endtask

   initial
   begin
      void'($urandom(32'h0e632b07));
      reset_n   = 1'b0;
      load_en   = 1'b0;
      load_addr = 16'd0;
      load_data = 16'd0;
      peek_addr = 16'd0;
      test_mov_store();
      test_add_sub();
      test_branches();
      test_loop();
      test_single_ops();
      test_illegal();
      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule
